// ==== aes_core/aes_key_expand.sv ====
`timescale 1ns/1ps

`include "aes_settings.svh"

module aes_key_expand
  import aes_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  aes_block_t key,
  input  logic       key_start,
  input  aes_round_t round_idx,
  output aes_block_t round_key,
  output logic       keys_ready
);

// One schedule step, RotWord then SubWord then Rcon
function automatic aes_block_t next_round_key(
  input aes_block_t rk,
  input logic [7:0] rcon
);
  logic [31:0] w0, w1, w2, w3, t;
  logic [31:0] n0, n1, n2, n3;
  w0 = rk[15:12];
  w1 = rk[11:8];
  w2 = rk[7:4];
  w3 = rk[3:0];
  t  = {sbox(w3[23:16]) ^ rcon, sbox(w3[15:8]), sbox(w3[7:0]), sbox(w3[31:24])};
  n0 = w0 ^ t;
  n1 = w1 ^ n0;
  n2 = w2 ^ n1;
  n3 = w3 ^ n2;
  return {n0, n1, n2, n3};
endfunction

logic       busy_q;
aes_round_t cnt_q;
logic [7:0] rcon_q;
aes_block_t rk_q [`AES_ROUNDS + 1];
aes_block_t rk_next;

// Previous entry feeds the next one
assign rk_next = next_round_key(rk_q[cnt_q - 1'b1], rcon_q);

always_ff @(posedge aclk or negedge aresetn)
begin
  if (!aresetn)
  begin
    busy_q     <= 1'b0;
    keys_ready <= 1'b0;
    cnt_q      <= '0;
    rcon_q     <= 8'h01;
  end
  else if (key_start)
  begin
    // restart even mid-expansion
    busy_q     <= 1'b1;
    keys_ready <= 1'b0;
    cnt_q      <= aes_round_t'(1);
    rcon_q     <= 8'h01;
  end
  else if (busy_q)
  begin
    cnt_q  <= cnt_q + 1'b1;
    rcon_q <= xtime(rcon_q);
    if (cnt_q == aes_round_t'(`AES_ROUNDS))
    begin
      busy_q     <= 1'b0;
      keys_ready <= 1'b1;
    end
  end
end

// Round key storage
always_ff @(posedge aclk)
begin
  if (key_start)
    rk_q[0] <= key;
  else if (busy_q)
    rk_q[cnt_q] <= rk_next;
end

assign round_key = rk_q[round_idx];

endmodule

// ==== aes_core/aes_round_engine.sv ====
`timescale 1ns/1ps

`include "aes_settings.svh"

module aes_round_engine
  import aes_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       in_valid,
  input  aes_block_t in_block,
  output logic       in_ready,
  output logic       out_valid,
  output aes_block_t out_block,
  input  logic       out_ready,
  input  logic       keys_ready,
  input  aes_block_t round_key,
  output aes_round_t round_idx
);

// SubBytes, ShiftRows, MixColumns and AddRoundKey in one pass
function automatic aes_block_t cipher_round(
  input aes_block_t s,
  input aes_block_t k,
  input logic       last
);
  logic [7:0] sh [4][4];
  logic [7:0] a0, a1, a2, a3;
  aes_block_t o;
  // Row r rotates left by r columns
  for (int r = 0; r < 4; r++)
  begin
    for (int c = 0; c < 4; c++)
    begin
      sh[r][c] = sbox(s[15 - (r + 4 * ((c + r) % 4))]);
    end
  end
  for (int c = 0; c < 4; c++)
  begin
    a0 = sh[0][c];
    a1 = sh[1][c];
    a2 = sh[2][c];
    a3 = sh[3][c];
    if (last)
    begin
      o[15 - 4 * c] = a0;
      o[14 - 4 * c] = a1;
      o[13 - 4 * c] = a2;
      o[12 - 4 * c] = a3;
    end
    else
    begin
      o[15 - 4 * c] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
      o[14 - 4 * c] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
      o[13 - 4 * c] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
      o[12 - 4 * c] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    end
  end
  return o ^ k;
endfunction

engine_state_e eng_state_q;
aes_round_t    rnd_q;
aes_block_t    blk_q;
logic          accept;
logic          last_round;

assign in_ready   = (eng_state_q == ENG_IDLE) && keys_ready;
assign accept     = in_valid && in_ready;
assign last_round = (rnd_q == aes_round_t'(`AES_ROUNDS));

// Key 0 while idle for the initial whitening
assign round_idx = (eng_state_q == ENG_RUN) ? rnd_q : '0;

// ------------------------------------------------------------
// Control FSM
// ------------------------------------------------------------
always_ff @(posedge aclk or negedge aresetn)
begin
  if (!aresetn)
  begin
    eng_state_q <= ENG_IDLE;
    rnd_q       <= '0;
  end
  else
  begin
    case (eng_state_q)
      ENG_IDLE:
        if (accept)
        begin
          eng_state_q <= ENG_RUN;
          rnd_q       <= aes_round_t'(1);
        end
      ENG_RUN:
        if (last_round)
          eng_state_q <= ENG_OUT;
        else
          rnd_q <= rnd_q + 1'b1;
      ENG_OUT:
        if (out_ready)
          eng_state_q <= ENG_IDLE;
      default:
        eng_state_q <= ENG_IDLE;
    endcase
  end
end

// Cipher state
always_ff @(posedge aclk)
begin
  if (accept)
    blk_q <= in_block ^ round_key;
  else if (eng_state_q == ENG_RUN)
    blk_q <= cipher_round(blk_q, round_key, last_round);
end

assign out_valid = (eng_state_q == ENG_OUT);
assign out_block = blk_q;

a_out_stable: assert property (
  @(posedge aclk) disable iff (!aresetn)
  out_valid && !out_ready |=> out_valid && $stable(out_block)
);

endmodule

// ==== common/aes_pkg.sv ====
`include "aes_settings.svh"

package aes_pkg;

  // Byte 15 is the first byte of the FIPS-197 input
  typedef logic [15:0][7:0] aes_block_t;

  typedef logic [$clog2(`AES_ROUNDS + 1)-1:0] aes_round_t;

  typedef enum logic [1:0] {
    ENG_IDLE = 2'd0,
    ENG_RUN  = 2'd1,
    ENG_OUT  = 2'd2
  } engine_state_e;

  // ----------------------------------------------------------
  // Forward S-box, entry 0 first
  // ----------------------------------------------------------
  localparam logic [0:255][7:0] AES_SBOX = {
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  function automatic logic [7:0] sbox(input logic [7:0] x);
    return AES_SBOX[x];
  endfunction

  // Multiply by x in GF(2^8)
  function automatic logic [7:0] xtime(input logic [7:0] x);
    return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

// ==== common/aes_settings.svh ====
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// AXI-Lite bus widths
`define AXIL_DATA_BITS 32
`define AXIL_ADDR_BITS 5

// Number of 32-bit register slots in the control map
`define AES_NUM_REGS 8

// AES-128 round count
`define AES_ROUNDS 10

`endif

// ==== common/axil_pkg.sv ====
`include "aes_settings.svh"

package axil_pkg;

  // Byte offset bits and register index bits of an address
  localparam int AXIL_ADDR_LSB     = $clog2(`AXIL_DATA_BITS / 8);
  localparam int AXIL_REG_IDX_BITS = $clog2(`AES_NUM_REGS);

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axil_resp_t;

  // ----------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------
  typedef struct packed {
    logic [`AXIL_ADDR_BITS-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [`AXIL_ADDR_BITS-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [`AXIL_DATA_BITS-1:0]   data;
    logic [`AXIL_DATA_BITS/8-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [`AXIL_DATA_BITS-1:0] data;
    axil_resp_t                 resp;
  } axil_r_t;

  typedef struct packed {
    axil_resp_t resp;
  } axil_b_t;

  // Register map, KEY0 holds the least significant key word
  typedef enum logic [AXIL_REG_IDX_BITS-1:0] {
    REG_KEY0   = 3'd0,
    REG_KEY1   = 3'd1,
    REG_KEY2   = 3'd2,
    REG_KEY3   = 3'd3,
    REG_STATUS = 3'd4
  } aes_reg_e;

endpackage

// ==== dv/tb_aes_top.sv ====
`timescale 1ns/1ps

`include "aes_settings.svh"

module tb_aes_top
  import axil_pkg::*;
  import aes_pkg::*;
();

localparam int TIMEOUT_CYCLES = 200;
localparam int NUM_VECTORS    = 3;

// Raw words for the register test with KEY3 first
localparam logic [3:0][31:0] REG_WORDS = {
  32'h7654_3210, 32'hfedc_ba98, 32'h89ab_cdef, 32'h0123_4567
};

typedef struct packed {
  aes_block_t key;
  aes_block_t plain;
  aes_block_t cipher;
} vector_t;

logic       aclk;
logic       aresetn;
axil_aw_t   aw;
logic       aw_valid;
logic       aw_ready;
axil_w_t    w;
logic       w_valid;
logic       w_ready;
axil_b_t    b;
logic       b_valid;
logic       b_ready;
axil_ar_t   ar;
logic       ar_valid;
logic       ar_ready;
axil_r_t    r;
logic       r_valid;
logic       r_ready;
logic       in_valid;
aes_block_t in_block;
logic       in_ready;
logic       out_valid;
aes_block_t out_block;
logic       out_ready;

vector_t      vectors [NUM_VECTORS];
integer       seed;
int           errors;
int           test_errors;
int           tests;
int           failed_tests;
int           sent;
int           received;
int           latency;
int           stall;
logic [31:0]  rdata;
logic [127:0] result;

aes_top i_dut (.*);

always #50 aclk = ~aclk;

// ------------------------------------------------------------
// Reporting
// ------------------------------------------------------------
task automatic report_value(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
  $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
  errors++;
endtask

task automatic report_problem(input string what);
  $display("Error at %0t: %s", $time, what);
  errors++;
endtask

task automatic finish_test(input string name);
  tests++;
  if (errors == test_errors)
    $display("Test %0d %s: ok", tests, name);
  else
  begin
    failed_tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - test_errors);
  end
  test_errors = errors;
endtask

function automatic logic [`AXIL_ADDR_BITS-1:0] reg_addr(input logic [2:0] idx);
  return {idx, 2'b00};
endfunction

// ------------------------------------------------------------
// AXI-Lite master
// ------------------------------------------------------------
task automatic axil_write(input logic [`AXIL_ADDR_BITS-1:0] addr,
                          input logic [31:0] data, input logic [3:0] strb);
  int cnt;
  @(negedge aclk);
  aw.addr  = addr;
  w.data   = data;
  w.strb   = strb;
  aw_valid = 1'b1;
  w_valid  = 1'b1;
  b_ready  = 1'b1;
  cnt = 0;
  while (!(aw_ready && w_ready) && cnt < TIMEOUT_CYCLES)
  begin
    @(negedge aclk);
    cnt++;
  end
  if (!(aw_ready && w_ready))
    report_problem("write address and data were never accepted");
  @(negedge aclk);
  aw_valid = 1'b0;
  w_valid  = 1'b0;
  cnt = 0;
  while (!b_valid && cnt < TIMEOUT_CYCLES)
  begin
    @(negedge aclk);
    cnt++;
  end
  if (!b_valid)
    report_problem("timeout waiting for the write response");
  else if (b.resp !== RESP_OKAY)
    report_value("b.resp", 128'(b.resp), 128'(RESP_OKAY));
  @(negedge aclk);
  b_ready = 1'b0;
endtask

task automatic axil_read(input logic [`AXIL_ADDR_BITS-1:0] addr,
                         output logic [31:0] data);
  int cnt;
  @(negedge aclk);
  ar.addr  = addr;
  ar_valid = 1'b1;
  r_ready  = 1'b1;
  cnt = 0;
  while (!ar_ready && cnt < TIMEOUT_CYCLES)
  begin
    @(negedge aclk);
    cnt++;
  end
  if (!ar_ready)
    report_problem("read address was never accepted");
  @(negedge aclk);
  ar_valid = 1'b0;
  cnt = 0;
  while (!r_valid && cnt < TIMEOUT_CYCLES)
  begin
    @(negedge aclk);
    cnt++;
  end
  data = r.data;
  if (!r_valid)
    report_problem("timeout waiting for read data");
  else if (r.resp !== RESP_OKAY)
    report_value("r.resp", 128'(r.resp), 128'(RESP_OKAY));
  @(negedge aclk);
  r_ready = 1'b0;
endtask

// ------------------------------------------------------------
// Key load and block streams
// ------------------------------------------------------------
task automatic load_key(input logic [127:0] k);
  logic [31:0] status;
  int          cnt;
  for (int i = 0; i < 4; i++)
    axil_write(reg_addr(3'(i)), k[32 * i +: 32], 4'hf);
  // Engine takes no blocks while the schedule restarts
  if (in_ready !== 1'b0)
    report_problem("in_ready high right after a key write");
  axil_read(reg_addr(REG_STATUS), status);
  if (status[0] !== 1'b0)
    report_value("status.keys_ready", 128'(status[0]), 128'(0));
  cnt = 0;
  while (!in_ready && cnt < TIMEOUT_CYCLES)
  begin
    @(negedge aclk);
    cnt++;
  end
  if (!in_ready)
    report_problem("timeout waiting for the round keys");
endtask

task automatic send_block(input logic [127:0] plain);
  int cnt;
  @(negedge aclk);
  in_block = plain;
  in_valid = 1'b1;
  cnt = 0;
  while (!in_ready && cnt < TIMEOUT_CYCLES)
  begin
    @(negedge aclk);
    cnt++;
  end
  if (!in_ready)
    report_problem("plaintext was never accepted");
  else
    sent++;
  @(negedge aclk);
  in_valid = 1'b0;
endtask

// Stall holds out_ready low for that many cycles once out_valid is up
task automatic receive_block(input int stall_cycles, input logic [127:0] expected,
                             output logic [127:0] blk, output int cycles);
  int cnt;
  out_ready = (stall_cycles == 0);
  cnt = 0;
  while (!out_valid && cnt < TIMEOUT_CYCLES)
  begin
    @(negedge aclk);
    cnt++;
  end
  cycles = cnt;
  blk    = '0;
  if (!out_valid)
    report_problem("timeout waiting for the ciphertext");
  else
  begin
    for (int i = 0; i < stall_cycles; i++)
    begin
      @(negedge aclk);
      if (!out_valid)
        report_problem("out_valid dropped before out_ready");
      if (out_block !== expected)
        report_value("out_block", out_block, expected);
      if (in_ready)
        report_problem("in_ready high while a result waits");
    end
    out_ready = 1'b1;
    blk = out_block;
    received++;
    @(negedge aclk);
    if (out_valid)
      report_problem("ciphertext delivered twice");
  end
  out_ready = 1'b0;
endtask

// ------------------------------------------------------------
// Test sequence
// ------------------------------------------------------------
initial
begin
  aclk     = 1'b0;
  aresetn  = 1'b0;
  aw       = '0;
  aw_valid = 1'b0;
  w        = '0;
  w_valid  = 1'b0;
  b_ready  = 1'b0;
  ar       = '0;
  ar_valid = 1'b0;
  r_ready  = 1'b0;
  in_valid = 1'b0;
  in_block = '0;
  out_ready = 1'b0;
  seed     = 32'h96b3_7262;
  errors   = 0;
  test_errors = 0;
  tests    = 0;
  failed_tests = 0;
  sent     = 0;
  received = 0;

  // FIPS-197 C.1, FIPS-197 B, all-zero key and block
  vectors[0] = '{key:    128'h000102030405060708090a0b0c0d0e0f,
                 plain:  128'h00112233445566778899aabbccddeeff,
                 cipher: 128'h69c4e0d86a7b0430d8cdb78070b4c55a};
  vectors[1] = '{key:    128'h2b7e151628aed2a6abf7158809cf4f3c,
                 plain:  128'h3243f6a8885a308d313198a2e0370734,
                 cipher: 128'h3925841d02dc09fbdc118597196a0b32};
  vectors[2] = '{key:    128'h0,
                 plain:  128'h0,
                 cipher: 128'h66e94bd4ef8a2c3b884cfa59ca342b2e};

  repeat (5) @(posedge aclk);
  @(negedge aclk);
  aresetn = 1'b1;
  if ({aw_ready, w_ready, ar_ready, b_valid, r_valid, in_ready, out_valid} !== 7'b0)
    report_problem("a ready or valid output is high after reset");
  finish_test("reset values");

  for (int i = 0; i < 4; i++)
    axil_write(reg_addr(3'(i)), REG_WORDS[i], 4'hf);
  for (int i = 0; i < 4; i++)
  begin
    axil_read(reg_addr(3'(i)), rdata);
    if (rdata !== REG_WORDS[i])
      report_value($sformatf("key word %0d", i), 128'(rdata), 128'(REG_WORDS[i]));
  end
  // Bytes 0 and 2 of 89abcdef replaced
  axil_write(reg_addr(REG_KEY1), 32'ha5a5_a5a5, 4'b0101);
  axil_read(reg_addr(REG_KEY1), rdata);
  if (rdata !== 32'h89a5_cda5)
    report_value("key word 1 after strobed write", 128'(rdata), 128'(32'h89a5_cda5));
  for (int i = 5; i < 8; i++)
  begin
    axil_read(reg_addr(3'(i)), rdata);
    if (rdata !== 32'h0)
      report_value($sformatf("unmapped register %0d", i), 128'(rdata), 128'(0));
  end
  finish_test("register access");

  load_key(vectors[0].key);
  repeat (`AES_ROUNDS + 1) @(negedge aclk);
  axil_read(reg_addr(REG_STATUS), rdata);
  if (rdata !== 32'h1)
    report_value("status", 128'(rdata), 128'(1));
  finish_test("key status");

  for (int i = 0; i < NUM_VECTORS; i++)
  begin
    load_key(vectors[i].key);
    send_block(vectors[i].plain);
    receive_block(0, vectors[i].cipher, result, latency);
    if (result !== vectors[i].cipher)
      report_value("out_block", result, vectors[i].cipher);
    if (latency != `AES_ROUNDS)
      report_value("latency", 128'(latency), 128'(`AES_ROUNDS));
    finish_test($sformatf("encrypt vector %0d", i));
  end

  // Random stretches of out_ready low
  for (int i = 0; i < NUM_VECTORS; i++)
  begin
    load_key(vectors[i].key);
    for (int n = 0; n < 3; n++)
    begin
      stall = 1 + ($unsigned($random(seed)) % 7);
      send_block(vectors[i].plain);
      receive_block(stall, vectors[i].cipher, result, latency);
      if (result !== vectors[i].cipher)
        report_value("out_block", result, vectors[i].cipher);
    end
    finish_test($sformatf("back-pressure vector %0d", i));
  end

  if (sent != received)
    report_problem($sformatf("%0d blocks sent but %0d received", sent, received));
  finish_test("block count");

  $display("Tests %0d, failed tests %0d, failed checks %0d", tests, failed_tests, errors);
  if (errors == 0)
    $display("*** TEST PASSED ***");
  else
    $display("*** TEST FAILED ***");
  $finish;
end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_aes_top -o tb_aes_top

sim_output=$(./obj_dir/tb_aes_top)
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -qF '*** TEST PASSED ***'
then
  exit 0
fi
exit 1

// ==== sim.f ====
+incdir+common
common/axil_pkg.sv
common/aes_pkg.sv
source/aes_ctrl_slave.sv
aes_core/aes_key_expand.sv
aes_core/aes_round_engine.sv
source/aes_top.sv
dv/tb_aes_top.sv

// ==== source/aes_ctrl_slave.sv ====
`timescale 1ns/1ps

`include "aes_settings.svh"

module aes_ctrl_slave
  import axil_pkg::*;
  import aes_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,

  input  axil_aw_t   aw,
  input  logic       aw_valid,
  output logic       aw_ready,
  input  axil_w_t    w,
  input  logic       w_valid,
  output logic       w_ready,
  output axil_b_t    b,
  output logic       b_valid,
  input  logic       b_ready,
  input  axil_ar_t   ar,
  input  logic       ar_valid,
  output logic       ar_ready,
  output axil_r_t    r,
  output logic       r_valid,
  input  logic       r_ready,

  input  logic       keys_ready,
  output aes_block_t key,
  output logic       key_start
);

// ------------------------------------------------------------
// Declarations
// ------------------------------------------------------------
logic [3:0][`AXIL_DATA_BITS-1:0] key_q;
logic [`AXIL_DATA_BITS-1:0]      rdata_q;
logic [`AXIL_DATA_BITS-1:0]      rd_mux;
logic [AXIL_REG_IDX_BITS-1:0]    wr_sel;
logic [AXIL_REG_IDX_BITS-1:0]    rd_sel;
aes_reg_e                        wr_reg;
aes_reg_e                        rd_reg;
logic                            aw_en;
logic                            wr_en;
logic                            rd_en;

assign wr_sel = aw.addr[AXIL_ADDR_LSB +: AXIL_REG_IDX_BITS];
assign rd_sel = ar.addr[AXIL_ADDR_LSB +: AXIL_REG_IDX_BITS];
assign wr_reg = aes_reg_e'(wr_sel);
assign rd_reg = aes_reg_e'(rd_sel);

assign wr_en = aw_ready && aw_valid && w_ready && w_valid;
assign rd_en = ar_ready && ar_valid && !r_valid;

// ------------------------------------------------------------
// Write path
// ------------------------------------------------------------

// Address and data are taken together, one write in flight
always_ff @(posedge aclk or negedge aresetn)
begin
  if (!aresetn)
  begin
    aw_ready <= 1'b0;
    w_ready  <= 1'b0;
    aw_en    <= 1'b1;
  end
  else if (!aw_ready && aw_valid && w_valid && aw_en)
  begin
    aw_ready <= 1'b1;
    w_ready  <= 1'b1;
    aw_en    <= 1'b0;
  end
  else
  begin
    aw_ready <= 1'b0;
    w_ready  <= 1'b0;
    if (b_valid && b_ready)
      aw_en <= 1'b1;
  end
end

// Byte-strobed key words
always_ff @(posedge aclk)
begin
  if (wr_en && (wr_reg inside {REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3}))
  begin
    for (int i = 0; i < `AXIL_DATA_BITS / 8; i++)
    begin
      if (w.strb[i])
        key_q[wr_sel[1:0]][8 * i +: 8] <= w.data[8 * i +: 8];
    end
  end
end

// Top key word kicks off the schedule
always_ff @(posedge aclk or negedge aresetn)
begin
  if (!aresetn)
    key_start <= 1'b0;
  else
    key_start <= wr_en && (wr_reg == REG_KEY3) && (|w.strb);
end

always_ff @(posedge aclk or negedge aresetn)
begin
  if (!aresetn)
    b_valid <= 1'b0;
  else if (wr_en && !b_valid)
    b_valid <= 1'b1;
  else if (b_valid && b_ready)
    b_valid <= 1'b0;
end

assign b   = '{resp: RESP_OKAY};
assign key = key_q;

// ------------------------------------------------------------
// Read path
// ------------------------------------------------------------
always_ff @(posedge aclk or negedge aresetn)
begin
  if (!aresetn)
    ar_ready <= 1'b0;
  else
    ar_ready <= !ar_ready && ar_valid && !r_valid;
end

always_comb
begin
  rd_mux = '0;
  case (rd_reg)
    REG_KEY0:   rd_mux = key_q[0];
    REG_KEY1:   rd_mux = key_q[1];
    REG_KEY2:   rd_mux = key_q[2];
    REG_KEY3:   rd_mux = key_q[3];
    REG_STATUS: rd_mux[0] = keys_ready;
    default:    rd_mux = '0;
  endcase
end

always_ff @(posedge aclk)
begin
  if (rd_en)
    rdata_q <= rd_mux;
end

always_ff @(posedge aclk or negedge aresetn)
begin
  if (!aresetn)
    r_valid <= 1'b0;
  else if (rd_en)
    r_valid <= 1'b1;
  else if (r_valid && r_ready)
    r_valid <= 1'b0;
end

assign r = '{data: rdata_q, resp: RESP_OKAY};

// ------------------------------------------------------------
// Checks
// ------------------------------------------------------------
a_bvalid_hold: assert property (
  @(posedge aclk) disable iff (!aresetn)
  b_valid && !b_ready |=> b_valid
);

a_key_start_pulse: assert property (
  @(posedge aclk) disable iff (!aresetn)
  key_start |=> !key_start
);

endmodule

// ==== source/aes_top.sv ====
`timescale 1ns/1ps

module aes_top
  import axil_pkg::*;
  import aes_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,

  // AXI-Lite control
  input  axil_aw_t   aw,
  input  logic       aw_valid,
  output logic       aw_ready,
  input  axil_w_t    w,
  input  logic       w_valid,
  output logic       w_ready,
  output axil_b_t    b,
  output logic       b_valid,
  input  logic       b_ready,
  input  axil_ar_t   ar,
  input  logic       ar_valid,
  output logic       ar_ready,
  output axil_r_t    r,
  output logic       r_valid,
  input  logic       r_ready,

  // Plaintext in, ciphertext out
  input  logic       in_valid,
  input  aes_block_t in_block,
  output logic       in_ready,
  output logic       out_valid,
  output aes_block_t out_block,
  input  logic       out_ready
);

aes_block_t key;
logic       key_start;
logic       keys_ready;
aes_round_t round_idx;
aes_block_t round_key;

aes_ctrl_slave i_ctrl (
  .aclk       (aclk),
  .aresetn    (aresetn),
  .aw         (aw),
  .aw_valid   (aw_valid),
  .aw_ready   (aw_ready),
  .w          (w),
  .w_valid    (w_valid),
  .w_ready    (w_ready),
  .b          (b),
  .b_valid    (b_valid),
  .b_ready    (b_ready),
  .ar         (ar),
  .ar_valid   (ar_valid),
  .ar_ready   (ar_ready),
  .r          (r),
  .r_valid    (r_valid),
  .r_ready    (r_ready),
  .keys_ready (keys_ready),
  .key        (key),
  .key_start  (key_start)
);

aes_key_expand i_key_expand (
  .aclk       (aclk),
  .aresetn    (aresetn),
  .key        (key),
  .key_start  (key_start),
  .round_idx  (round_idx),
  .round_key  (round_key),
  .keys_ready (keys_ready)
);

aes_round_engine i_engine (
  .aclk       (aclk),
  .aresetn    (aresetn),
  .in_valid   (in_valid),
  .in_block   (in_block),
  .in_ready   (in_ready),
  .out_valid  (out_valid),
  .out_block  (out_block),
  .out_ready  (out_ready),
  .keys_ready (keys_ready),
  .round_key  (round_key),
  .round_idx  (round_idx)
);

endmodule
